//--- tb.f
design/mem_system_pkg.sv
design/mem_if.sv
design/bus_fsm.sv
design/run_timer.sv
design/ctrl_regs.sv
design/l2_sram.sv
design/bootrom.sv
design/mem_system.sv
test/mem_system_assert.sv
test/tb_mem_system.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mem_system
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_mem_system)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

//--- test/tb_mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;
  import mem_system_pkg::*;

  localparam int unsigned NumCores    = 4;
  localparam int unsigned L2AddrWidth = 8;
  localparam int          WaitLimit   = 8;
  localparam logic [1:0]  OpRead      = 2'd0;
  localparam logic [1:0]  OpWrite     = 2'd1;
  localparam logic [1:0]  OpFetch     = 2'd2;
  localparam logic [1:0]  OpIdle      = 2'd3;
  // Cycle count model states
  localparam int          CycKnown    = 0;
  localparam int          CycRunning  = 1;

  typedef struct packed {
    logic [1:0] op;
    logic       rnd;
    addr_t      addr;
    data_t      data;
    strb_t      be;
    logic       err;
  } entry_t;

  localparam int NumEntries = 32;
  localparam int CycleLimit = 6 * NumEntries + 100;

  // op, random data, address, data or idle cycles, byte enables, expected err
  localparam entry_t StimTable [NumEntries] = '{
    '{OpRead,  1'b0, 32'h4000_0000, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'h4000_0004, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'h4000_0008, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'h4000_0010, 32'h0000_0000, 4'h0, 1'b0},
    '{OpWrite, 1'b1, 32'h8000_0000, 32'h0000_0000, 4'hf, 1'b0},
    '{OpRead,  1'b0, 32'h8000_0000, 32'h0000_0000, 4'h0, 1'b0},
    '{OpWrite, 1'b1, 32'h8000_0004, 32'h0000_0000, 4'h3, 1'b0},
    '{OpWrite, 1'b1, 32'h8000_0404, 32'h0000_0000, 4'hc, 1'b0},
    '{OpRead,  1'b0, 32'h9fff_fc04, 32'h0000_0000, 4'h0, 1'b0},
    '{OpWrite, 1'b1, 32'h9fff_fffc, 32'h0000_0000, 4'h9, 1'b0},
    '{OpRead,  1'b0, 32'h9fff_fffc, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'ha000_0000, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'ha000_003c, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'ha000_0044, 32'h0000_0000, 4'h0, 1'b0},
    '{OpWrite, 1'b0, 32'ha000_0008, 32'h1234_5678, 4'hf, 1'b0},
    '{OpRead,  1'b0, 32'ha000_0008, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 1'b1},
    '{OpWrite, 1'b1, 32'h4001_0000, 32'h0000_0000, 4'hf, 1'b1},
    '{OpRead,  1'b0, 32'hc000_0000, 32'h0000_0000, 4'h0, 1'b1},
    '{OpWrite, 1'b1, 32'h0000_0000, 32'h0000_0000, 4'hf, 1'b1},
    '{OpRead,  1'b0, 32'h8000_0000, 32'h0000_0000, 4'h0, 1'b0},
    '{OpFetch, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 1'b0},
    '{OpWrite, 1'b0, 32'h4000_0000, 32'h0000_0005, 4'hf, 1'b0},
    '{OpWrite, 1'b0, 32'h4000_0004, 32'h0000_0aa0, 4'hf, 1'b0},
    '{OpIdle,  1'b0, 32'h0000_0000, 32'h0000_0004, 4'h0, 1'b0},
    '{OpWrite, 1'b0, 32'h4000_0004, 32'h0000_1235, 4'hf, 1'b0},
    '{OpRead,  1'b0, 32'h4000_0004, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'h4000_0008, 32'h0000_0000, 4'h0, 1'b0},
    '{OpIdle,  1'b0, 32'h0000_0000, 32'h0000_0003, 4'h0, 1'b0},
    '{OpWrite, 1'b0, 32'h4000_0008, 32'hffff_ffff, 4'hf, 1'b0},
    '{OpRead,  1'b0, 32'h4000_0008, 32'h0000_0000, 4'h0, 1'b0},
    '{OpRead,  1'b0, 32'h4000_0000, 32'h0000_0000, 4'h0, 1'b0}
  };

  logic                clk_i;
  logic                rst_n_i;
  logic                fetch_en_i;
  logic                host_req_i;
  logic                host_we_i;
  addr_t               host_addr_i;
  data_t               host_wdata_i;
  strb_t               host_be_i;
  logic                host_gnt_o;
  logic                host_rvalid_o;
  data_t               host_rdata_o;
  logic                host_err_o;
  logic                eoc_valid_o;
  logic                busy_o;
  logic [NumCores-1:0] wake_up_o;

  data_t       ref_l2 [2 ** L2AddrWidth];
  data_t       wake_model;
  data_t       eoc_model;
  data_t       cyc_exp;
  logic        running;
  int          cyc_mode;
  int          start_cycle;
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          cycle_count;

  mem_system #(
    .NumCores   (NumCores   ),
    .L2AddrWidth(L2AddrWidth)
  ) dut_i (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .fetch_en_i   (fetch_en_i   ),
    .host_req_i   (host_req_i   ),
    .host_we_i    (host_we_i    ),
    .host_addr_i  (host_addr_i  ),
    .host_wdata_i (host_wdata_i ),
    .host_be_i    (host_be_i    ),
    .host_gnt_o   (host_gnt_o   ),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o ),
    .host_err_o   (host_err_o   ),
    .eoc_valid_o  (eoc_valid_o  ),
    .busy_o       (busy_o       ),
    .wake_up_o    (wake_up_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = {1'b0, s[31:1]};
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per data bit
  task automatic rand_word(output data_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  function automatic target_e region_of(input addr_t a);
    if (a >= CtrlBase && a <= CtrlEnd) begin
      return CtrlRegs;
    end else if (a >= L2Base && a <= L2End) begin
      return L2Mem;
    end else if (a >= RomBase && a <= RomEnd) begin
      return BootRom;
    end
    return NoTarget;
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at time %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_outputs();
    check_value("busy_o", data_t'(running), data_t'(busy_o));
    check_value("eoc_valid_o", data_t'(eoc_model[0]), data_t'(eoc_valid_o));
    check_value("wake_up_o", data_t'(wake_model[NumCores-1:0]), data_t'(wake_up_o));
  endtask

  task automatic update_model(input target_e region, input addr_t a, input data_t wdata,
                              input strb_t be);
    logic [CtrlOffWidth-1:0] offset;
    logic [L2AddrWidth-1:0]  idx;
    offset = a[CtrlOffWidth+1:2];
    idx    = a[L2AddrWidth+1:2];
    if (region == CtrlRegs && offset == RegWakeUp) begin
      wake_model = wdata;
    end else if (region == CtrlRegs && offset == RegEoc) begin
      eoc_model = wdata;
      if (wdata[0] && cyc_mode == CycRunning) begin
        running  = 1'b0;
        // One increment per edge strictly between start and stop
        cyc_exp  = data_t'(cycle_count - start_cycle - 1);
        cyc_mode = CycKnown;
      end
    end else if (region == L2Mem) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ref_l2[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
  endtask

  task automatic expected_read(input target_e region, input addr_t a, output data_t exp,
                               output logic valid);
    logic [CtrlOffWidth-1:0] offset;
    offset = a[CtrlOffWidth+1:2];
    valid  = 1'b1;
    exp    = '0;
    if (region == L2Mem) begin
      exp = ref_l2[a[L2AddrWidth+1:2]];
    end else if (region == BootRom) begin
      exp = BootImage[a[5:2]];
    end else if (region == CtrlRegs && offset == RegWakeUp) begin
      exp = wake_model;
    end else if (region == CtrlRegs && offset == RegEoc) begin
      exp = eoc_model;
    end else if (region == CtrlRegs && offset == RegCycles) begin
      valid = (cyc_mode == CycKnown);
      exp   = cyc_exp;
    end
  endtask

  task automatic run_access(input entry_t e);
    data_t   wdata;
    data_t   exp;
    logic    valid;
    int      waited;
    target_e region;
    wdata  = e.data;
    region = region_of(e.addr);
    if (e.rnd) begin
      rand_word(wdata);
    end
    @(negedge clk_i);
    host_req_i   = 1'b1;
    host_we_i    = (e.op == OpWrite);
    host_addr_i  = e.addr;
    host_wdata_i = wdata;
    host_be_i    = e.be;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!host_gnt_o && waited < WaitLimit);
    if (!host_gnt_o) begin
      errors++;
      $display("No grant for the access to %h within %0d cycles", e.addr, WaitLimit);
      host_req_i = 1'b0;
      return;
    end
    check_value("host_gnt_o latency", 32'd1, data_t'(waited));
    waited = 0;
    do begin
      @(negedge clk_i);
      host_req_i = 1'b0;
      waited++;
    end while (!host_rvalid_o && waited < WaitLimit);
    if (!host_rvalid_o) begin
      errors++;
      $display("No response for the access to %h within %0d cycles", e.addr, WaitLimit);
      return;
    end
    check_value("host_rvalid_o latency", 32'd1, data_t'(waited));
    check_value("host_err_o", data_t'(e.err), data_t'(host_err_o));
    if (e.op == OpWrite) begin
      update_model(region, e.addr, wdata, e.be);
    end else begin
      expected_read(region, e.addr, exp, valid);
      if (valid) begin
        check_value("host_rdata_o", exp, host_rdata_o);
      end
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CycleLimit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst_n_i      = 1'b0;
    fetch_en_i   = 1'b0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_be_i    = '0;
    errors       = 0;
    checks       = 0;
    lfsr_state   = 32'hfcb0d334;
    wake_model   = '0;
    eoc_model    = '0;
    cyc_exp      = '0;
    cyc_mode     = CycKnown;
    start_cycle  = 0;
    running      = 1'b0;
    for (int i = 0; i < 2 ** L2AddrWidth; i++) begin
      ref_l2[i] = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    check_value("host_gnt_o", '0, data_t'(host_gnt_o));
    check_value("host_rvalid_o", '0, data_t'(host_rvalid_o));
    check_value("host_err_o", '0, data_t'(host_err_o));
    check_outputs();
    for (int i = 0; i < NumEntries; i++) begin
      if (StimTable[i].op == OpFetch) begin
        @(negedge clk_i);
        fetch_en_i = 1'b1;
        @(negedge clk_i);
        fetch_en_i  = 1'b0;
        running     = 1'b1;
        cyc_mode    = CycRunning;
        start_cycle = cycle_count;
      end else if (StimTable[i].op == OpIdle) begin
        repeat (int'(StimTable[i].data)) @(negedge clk_i);
      end else begin
        run_access(StimTable[i]);
      end
      check_outputs();
    end
    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/mem_system_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system_assert (
  input wire logic clk_i,
  input wire logic rst_n_i,
  input wire logic req_i,
  input wire logic gnt_i,
  input wire logic rvalid_i,
  input wire logic eoc_valid_i
);

  // Response exactly one cycle after grant
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_i |=> rvalid_i)
    else $error("host_rvalid_o missing one cycle after host_gnt_o");

  rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> $past(gnt_i))
    else $error("host_rvalid_o without host_gnt_o in the cycle before");

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_i |-> req_i)
    else $error("host_gnt_o high while host_req_i is low");

  rvalid_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |=> !rvalid_i)
    else $error("host_rvalid_o high for two cycles in a row");

  eoc_low_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !eoc_valid_i)
    else $error("eoc_valid_o high in the cycle after reset");

endmodule

bind mem_system mem_system_assert i_mem_system_assert (
  .clk_i      (clk_i        ),
  .rst_n_i    (rst_n_i      ),
  .req_i      (host_req_i   ),
  .gnt_i      (host_gnt_o   ),
  .rvalid_i   (host_rvalid_o),
  .eoc_valid_i(eoc_valid_o  )
);

`default_nettype wire

//--- design/mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system #(
  parameter int unsigned NumCores    = 4,
  parameter int unsigned L2AddrWidth = 8
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   fetch_en_i,
  input  wire logic                   host_req_i,
  input  wire logic                   host_we_i,
  input  wire mem_system_pkg::addr_t  host_addr_i,
  input  wire mem_system_pkg::data_t  host_wdata_i,
  input  wire mem_system_pkg::strb_t  host_be_i,
  output logic                        host_gnt_o,
  output logic                        host_rvalid_o,
  output mem_system_pkg::data_t       host_rdata_o,
  output logic                        host_err_o,
  output logic                        eoc_valid_o,
  output logic                        busy_o,
  output logic [NumCores-1:0]         wake_up_o
);
  import mem_system_pkg::*;

  data_t cycles;
  logic  eoc_stop;

  mem_if ctrl_bus ();
  mem_if l2_bus ();
  mem_if rom_bus ();

  bus_fsm i_bus_fsm (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .host_req_i   (host_req_i   ),
    .host_we_i    (host_we_i    ),
    .host_addr_i  (host_addr_i  ),
    .host_wdata_i (host_wdata_i ),
    .host_be_i    (host_be_i    ),
    .host_gnt_o   (host_gnt_o   ),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o ),
    .host_err_o   (host_err_o   ),
    .ctrl_bus     (ctrl_bus     ),
    .l2_bus       (l2_bus       ),
    .rom_bus      (rom_bus      )
  );

  ctrl_regs #(
    .NumCores(NumCores)
  ) i_ctrl_regs (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .cycles_i   (cycles     ),
    .bus        (ctrl_bus   ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o),
    .eoc_stop_o (eoc_stop   )
  );

  l2_sram #(
    .L2AddrWidth(L2AddrWidth)
  ) i_l2_sram (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .bus    (l2_bus )
  );

  bootrom i_bootrom (
    .clk_i(clk_i  ),
    .bus  (rom_bus)
  );

  // Busy from fetch enable until the end-of-computation write
  run_timer i_run_timer (
    .clk_i   (clk_i     ),
    .rst_n_i (rst_n_i   ),
    .start_i (fetch_en_i),
    .stop_i  (eoc_stop  ),
    .busy_o  (busy_o    ),
    .cycles_o(cycles    )
  );

endmodule

`default_nettype wire

//--- design/bootrom.sv
`timescale 1ns/1ps
`default_nettype none

module bootrom (
  input  wire logic  clk_i,
  mem_if.tgt         bus
);
  import mem_system_pkg::*;

  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  logic [RomIdxWidth-1:0] idx;
  logic                   rd_en;
  data_t                  rdata_q;

  // Offsets beyond the image wrap around
  assign idx   = bus.addr[RomIdxWidth-1:0];
  assign rd_en = bus.req && !bus.we;

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= BootImage[idx];
    end
  end

  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/l2_sram.sv
`timescale 1ns/1ps
`default_nettype none

module l2_sram #(
  parameter int unsigned L2AddrWidth = 8
) (
  input  wire logic  clk_i,
  input  wire logic  rst_n_i,
  mem_if.tgt         bus
);
  import mem_system_pkg::*;

  localparam int unsigned NumWords = 2 ** L2AddrWidth;

  data_t                  mem_q [NumWords];
  data_t                  rdata_q;
  logic [L2AddrWidth-1:0] idx;

  // Upper index bits alias
  assign idx = bus.addr[L2AddrWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (bus.req && bus.we) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (bus.be[b]) begin
          mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs #(
  parameter int unsigned NumCores = 4
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire mem_system_pkg::data_t  cycles_i,
  mem_if.tgt                          bus,
  output logic [NumCores-1:0]         wake_up_o,
  output logic                        eoc_valid_o,
  output logic                        eoc_stop_o
);
  import mem_system_pkg::*;

  logic [CtrlOffWidth-1:0] offset;
  logic                    wr_en;
  logic                    rd_en;
  data_t                   wake_q;
  eoc_word_u               eoc_q;
  eoc_word_u               wr_word;
  data_t                   rdata_q;

  assign offset       = bus.addr[CtrlOffWidth-1:0];
  assign wr_en        = bus.req && bus.we;
  assign rd_en        = bus.req && !bus.we;
  assign wr_word.raw  = bus.wdata;

  // Full word writes only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wake_q    <= '0;
      eoc_q.raw <= '0;
    end else if (wr_en) begin
      case (offset)
        RegWakeUp: wake_q    <= bus.wdata;
        RegEoc:    eoc_q.raw <= bus.wdata;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (offset)
        RegWakeUp: rdata_q <= wake_q;
        RegEoc:    rdata_q <= eoc_q.raw;
        RegCycles: rdata_q <= cycles_i;
        default:   rdata_q <= '0;
      endcase
    end
  end

  // Stops the run timer at the same edge the word is stored
  assign eoc_stop_o = wr_en && (offset == RegEoc) && wr_word.fields.valid;

  assign wake_up_o   = wake_q[NumCores-1:0];
  assign eoc_valid_o = eoc_q.fields.valid;
  assign bus.rdata   = rdata_q;

endmodule

`default_nettype wire

//--- design/run_timer.sv
`timescale 1ns/1ps
`default_nettype none

module run_timer (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              start_i,
  input  wire logic              stop_i,
  output logic                   busy_o,
  output mem_system_pkg::data_t  cycles_o
);
  import mem_system_pkg::*;

  logic  busy_q;
  data_t count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      count_q <= '0;
    end else if (stop_i) begin
      // Stop wins over a start in the same cycle
      busy_q <= 1'b0;
    end else if (start_i) begin
      busy_q  <= 1'b1;
      count_q <= '0;
    end else if (busy_q && count_q != '1) begin
      count_q <= count_q + 32'd1;
    end
  end

  assign busy_o   = busy_q;
  assign cycles_o = count_q;

endmodule

`default_nettype wire

//--- design/bus_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fsm (
  input  wire logic                   clk_i,
  input  wire logic                   rst_n_i,
  input  wire logic                   host_req_i,
  input  wire logic                   host_we_i,
  input  wire mem_system_pkg::addr_t  host_addr_i,
  input  wire mem_system_pkg::data_t  host_wdata_i,
  input  wire mem_system_pkg::strb_t  host_be_i,
  output logic                        host_gnt_o,
  output logic                        host_rvalid_o,
  output mem_system_pkg::data_t       host_rdata_o,
  output logic                        host_err_o,
  mem_if.ctrl                         ctrl_bus,
  mem_if.ctrl                         l2_bus,
  mem_if.ctrl                         rom_bus
);
  import mem_system_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    Access,
    Resp
  } state_e;

  state_e  state_q, state_d;
  target_e tgt_d, tgt_q;
  addr_t   word_addr;
  logic    access;

  // Region decode of the address held until grant
  always_comb begin
    if (host_addr_i >= CtrlBase && host_addr_i <= CtrlEnd) begin
      tgt_d = CtrlRegs;
    end else if (host_addr_i >= L2Base && host_addr_i <= L2End) begin
      tgt_d = L2Mem;
    end else if (host_addr_i >= RomBase && host_addr_i <= RomEnd) begin
      tgt_d = BootRom;
    end else begin
      tgt_d = NoTarget;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (host_req_i) begin
          state_d = Access;
        end
      end
      Access:  state_d = Resp;
      Resp:    state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
      tgt_q   <= NoTarget;
    end else begin
      state_q <= state_d;
      if (access) begin
        tgt_q <= tgt_d;
      end
    end
  end

  assign access    = (state_q == Access);
  assign word_addr = {2'b00, host_addr_i[31:2]};

  assign ctrl_bus.req   = access && (tgt_d == CtrlRegs);
  assign ctrl_bus.we    = host_we_i;
  assign ctrl_bus.addr  = word_addr;
  assign ctrl_bus.wdata = host_wdata_i;
  assign ctrl_bus.be    = host_be_i;

  assign l2_bus.req   = access && (tgt_d == L2Mem);
  assign l2_bus.we    = host_we_i;
  assign l2_bus.addr  = word_addr;
  assign l2_bus.wdata = host_wdata_i;
  assign l2_bus.be    = host_be_i;

  // ROM sees writes too and drops them
  assign rom_bus.req   = access && (tgt_d == BootRom);
  assign rom_bus.we    = host_we_i;
  assign rom_bus.addr  = word_addr;
  assign rom_bus.wdata = host_wdata_i;
  assign rom_bus.be    = host_be_i;

  assign host_gnt_o    = access;
  assign host_rvalid_o = (state_q == Resp);
  assign host_err_o    = host_rvalid_o && (tgt_q == NoTarget);

  always_comb begin
    case (tgt_q)
      CtrlRegs: host_rdata_o = ctrl_bus.rdata;
      L2Mem:    host_rdata_o = l2_bus.rdata;
      BootRom:  host_rdata_o = rom_bus.rdata;
      default:  host_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_if;
  import mem_system_pkg::*;

  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  strb_t be;
  data_t rdata;

  // addr is a word index and rdata returns one cycle after req
  modport ctrl (
    output req, we, addr, wdata, be,
    input  rdata
  );

  modport tgt (
    input  req, we, addr, wdata, be,
    output rdata
  );

endinterface

`default_nettype wire

//--- design/mem_system_pkg.sv
`default_nettype none

package mem_system_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    CtrlRegs,
    L2Mem,
    BootRom,
    NoTarget
  } target_e;

  // Address map
  localparam addr_t CtrlBase = 32'h4000_0000;
  localparam addr_t CtrlEnd  = 32'h4000_FFFF;
  localparam addr_t L2Base   = 32'h8000_0000;
  localparam addr_t L2End    = 32'h9FFF_FFFF;
  localparam addr_t RomBase  = 32'hA000_0000;
  localparam addr_t RomEnd   = 32'hA000_FFFF;

  // Word offsets inside the 64 KiB control region
  localparam int unsigned CtrlOffWidth = 14;
  localparam logic [CtrlOffWidth-1:0] RegWakeUp = 14'd0;
  localparam logic [CtrlOffWidth-1:0] RegEoc    = 14'd1;
  localparam logic [CtrlOffWidth-1:0] RegCycles = 14'd2;

  typedef union packed {
    data_t raw;
    struct packed {
      logic [30:0] code;
      logic        valid;
    } fields;
  } eoc_word_u;

  localparam int unsigned RomWords = 16;

  localparam data_t BootImage [RomWords] = '{
    32'h0000_0297, 32'h0182_8293, 32'h0002_a283, 32'h0002_8067,
    32'hf140_2573, 32'h0000_0597, 32'h0245_8593, 32'h1050_0073,
    32'hffdf_f06f, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h8000_0000, 32'h0000_0000, 32'hdead_beef, 32'hcafe_f00d
  };

endpackage

`default_nettype wire
